// ==== flist.f ====
+incdir+tb
rtl/issue_pkg.sv
rtl/issue_if.sv
rtl/rs.sv
rtl/rs_regs.sv
rtl/alu_unit.sv
rtl/mult_unit.sv
rtl/issue_top.sv
tb/tb_issue_top.sv

// ==== rtl/alu_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module alu_unit import issue_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    issue_if.unit             issue,
    output logic              result_valid,
    output logic [prn_w-1:0]  result_prn,
    output logic [data_w-1:0] result_value
);

    logic [data_w-1:0] alu_out;

    always_comb begin
        case (issue.op)
            op_add:  alu_out = issue.op1 + issue.op2;
            op_sub:  alu_out = issue.op1 - issue.op2;
            op_and:  alu_out = issue.op1 & issue.op2;
            op_xor:  alu_out = issue.op1 ^ issue.op2;
            default: alu_out = '0;   // mul goes to the other unit
        endcase
    end

    // one cycle onto cdb lane 0
    always_ff @(posedge clock) begin
        if (reset) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= issue.valid;
        end
        result_prn   <= issue.dest_prn;
        result_value <= alu_out;
    end

endmodule

`default_nettype wire

// ==== rtl/issue_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface issue_if import issue_pkg::*; ();

    logic              valid;     // issue happens on every valid cycle
    op_e               op;
    logic [data_w-1:0] op1;       // both operands are values by now
    logic [data_w-1:0] op2;
    logic [prn_w-1:0]  dest_prn;

    modport station (
        output valid, op, op1, op2, dest_prn
    );

    // units always accept so no ready comes back
    modport unit (
        input valid, op, op1, op2, dest_prn
    );

endinterface

`default_nettype wire

// ==== rtl/issue_pkg.sv ====
`default_nettype none

package issue_pkg;

    localparam int rs_size   = 8;
    localparam int prn_w     = 6;
    localparam int data_w    = 32;
    localparam int cdb_lanes = 2;   // lane 0 alu, lane 1 mult
    localparam int cnt_w     = 4;   // holds 0..rs_size
    localparam int addr_w    = 8;

    typedef enum logic [2:0] {
        op_add = 3'd0,
        op_sub = 3'd1,
        op_and = 3'd2,
        op_xor = 3'd3,
        op_mul = 3'd4
    } op_e;

    typedef enum logic [0:0] {
        fu_alu  = 1'b0,
        fu_mult = 1'b1
    } fu_e;

    // one station slot
    typedef struct packed {
        logic              valid;
        op_e               op;
        logic              op1_ready;
        logic              op2_ready;
        logic [data_w-1:0] op1;       // tag in low bits until ready
        logic [data_w-1:0] op2;
        logic [prn_w-1:0]  dest_prn;
    } rs_entry_t;

    // apb register map
    localparam logic [addr_w-1:0] addr_ctrl     = 8'h00;
    localparam logic [addr_w-1:0] addr_alert    = 8'h04;
    localparam logic [addr_w-1:0] addr_status   = 8'h08;
    localparam logic [addr_w-1:0] addr_alu_cnt  = 8'h0C;
    localparam logic [addr_w-1:0] addr_mult_cnt = 8'h10;

    // unit type follows from the opcode
    function automatic fu_e fu_of(input op_e op);
        return (op == op_mul) ? fu_mult : fu_alu;
    endfunction

endpackage

`default_nettype wire

// ==== rtl/issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module issue_top import issue_pkg::*; (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             dispatch_valid,
    input  op_e                              dispatch_op,
    input  logic                             op1_ready,
    input  logic [data_w-1:0]                op1,
    input  logic                             op2_ready,
    input  logic [data_w-1:0]                op2,
    input  logic [prn_w-1:0]                 dest_prn,
    output logic                             dispatch_ready,
    input  logic                             psel,
    input  logic                             penable,
    input  logic                             pwrite,
    input  logic [addr_w-1:0]                paddr,
    input  logic [data_w-1:0]                pwdata,
    output logic [data_w-1:0]                prdata,
    output logic                             pready,
    output logic                             pslverr,
    output logic [cdb_lanes-1:0]             cdb_valid,
    output logic [cdb_lanes-1:0][prn_w-1:0]  cdb_prn,
    output logic [cdb_lanes-1:0][data_w-1:0] cdb_value
);

    logic              alu_enable;
    logic              mult_enable;
    logic [cnt_w-1:0]  alert_depth;
    logic [cnt_w-1:0]  occupancy;
    logic              alu_valid;
    logic [prn_w-1:0]  alu_prn;
    logic [data_w-1:0] alu_value;
    logic              mult_valid;
    logic [prn_w-1:0]  mult_prn;
    logic [data_w-1:0] mult_value;

    issue_if alu_issue ();
    issue_if mult_issue ();

    // lane 0 alu, lane 1 mult
    assign cdb_valid = {mult_valid, alu_valid};
    assign cdb_prn   = {mult_prn, alu_prn};
    assign cdb_value = {mult_value, alu_value};

    rs rs0 (
        .clock(clock), .reset(reset),
        .dispatch_valid(dispatch_valid), .dispatch_op(dispatch_op),
        .op1_ready(op1_ready), .op1(op1), .op2_ready(op2_ready), .op2(op2),
        .dest_prn(dest_prn), .dispatch_ready(dispatch_ready),
        .cdb_valid(cdb_valid), .cdb_prn(cdb_prn), .cdb_value(cdb_value),
        .alu_enable(alu_enable), .mult_enable(mult_enable),
        .alert_depth(alert_depth), .occupancy(occupancy),
        .alu_issue(alu_issue.station), .mult_issue(mult_issue.station)
    );

    rs_regs regs0 (
        .clock(clock), .reset(reset),
        .psel(psel), .penable(penable), .pwrite(pwrite), .paddr(paddr),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .occupancy(occupancy),
        .alu_issued(alu_issue.valid), .mult_issued(mult_issue.valid),
        .alu_enable(alu_enable), .mult_enable(mult_enable),
        .alert_depth(alert_depth)
    );

    alu_unit alu0 (
        .clock(clock), .reset(reset), .issue(alu_issue.unit),
        .result_valid(alu_valid), .result_prn(alu_prn), .result_value(alu_value)
    );

    mult_unit mult0 (
        .clock(clock), .reset(reset), .issue(mult_issue.unit),
        .result_valid(mult_valid), .result_prn(mult_prn), .result_value(mult_value)
    );

endmodule

`default_nettype wire

// ==== rtl/mult_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mult_unit import issue_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    issue_if.unit             issue,
    output logic              result_valid,
    output logic [prn_w-1:0]  result_prn,
    output logic [data_w-1:0] result_value
);

    logic              s1_valid;
    logic [prn_w-1:0]  s1_prn;
    logic [data_w-1:0] s1_a;
    logic [data_w-1:0] s1_b;
    logic              s2_valid;
    logic [prn_w-1:0]  s2_prn;
    logic [data_w-1:0] s2_prod;   // low half of the product

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid     <= 1'b0;
            s2_valid     <= 1'b0;
            result_valid <= 1'b0;
        end else begin
            s1_valid     <= issue.valid && issue.op == op_mul;
            s2_valid     <= s1_valid;
            result_valid <= s2_valid;
        end
    end

    // data and tag ride alongside the valid bits
    always_ff @(posedge clock) begin
        s1_prn       <= issue.dest_prn;
        s1_a         <= issue.op1;
        s1_b         <= issue.op2;
        s2_prn       <= s1_prn;
        s2_prod      <= s1_a * s1_b;
        result_prn   <= s2_prn;
        result_value <= s2_prod;
    end

endmodule

`default_nettype wire

// ==== rtl/rs.sv ====
`timescale 1ns/1ns
`default_nettype none

module rs import issue_pkg::*; (
    input  logic                             clock,
    input  logic                             reset,
    input  logic                             dispatch_valid,
    input  op_e                              dispatch_op,
    input  logic                             op1_ready,
    input  logic [data_w-1:0]                op1,
    input  logic                             op2_ready,
    input  logic [data_w-1:0]                op2,
    input  logic [prn_w-1:0]                 dest_prn,
    output logic                             dispatch_ready,
    input  logic [cdb_lanes-1:0]             cdb_valid,
    input  logic [cdb_lanes-1:0][prn_w-1:0]  cdb_prn,
    input  logic [cdb_lanes-1:0][data_w-1:0] cdb_value,
    input  logic                             alu_enable,
    input  logic                             mult_enable,
    input  logic [cnt_w-1:0]                 alert_depth,
    output logic [cnt_w-1:0]                 occupancy,
    issue_if.station                         alu_issue,
    issue_if.station                         mult_issue
);

    rs_entry_t [rs_size-1:0] entries;
    rs_entry_t [rs_size-1:0] next_entries;
    rs_entry_t               incoming;
    rs_entry_t               alu_pick;
    rs_entry_t               mult_pick;

    logic [rs_size-1:0] free_vec;
    logic [rs_size-1:0] alloc;
    logic [rs_size-1:0] alu_req;
    logic [rs_size-1:0] mult_req;
    logic [rs_size-1:0] alu_gnt;
    logic [rs_size-1:0] mult_gnt;
    logic               dispatch_fire;
    logic               alu_fire;
    logic               mult_fire;

    // isolate the lowest set bit for a one-hot grant
    function automatic logic [rs_size-1:0] lowest(input logic [rs_size-1:0] req);
        return req & (~req + rs_size'(1));
    endfunction

    // swap waiting tags for values seen on any cdb lane
    function automatic rs_entry_t wake(input rs_entry_t e);
        rs_entry_t w;
        w = e;
        for (int l = 0; l < cdb_lanes; l++) begin
            if (cdb_valid[l] && !w.op1_ready && w.op1[prn_w-1:0] == cdb_prn[l]) begin
                w.op1_ready = 1'b1;
                w.op1       = cdb_value[l];
            end
            if (cdb_valid[l] && !w.op2_ready && w.op2[prn_w-1:0] == cdb_prn[l]) begin
                w.op2_ready = 1'b1;
                w.op2       = cdb_value[l];
            end
        end
        return w;
    endfunction

    // occupancy + alert must not pass the station size
    assign dispatch_ready = (cnt_w+1)'(occupancy) + (cnt_w+1)'(alert_depth)
                            <= (cnt_w+1)'(rs_size);
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    assign incoming = '{
        valid:     1'b1,
        op:        dispatch_op,
        op1_ready: op1_ready,
        op2_ready: op2_ready,
        op1:       op1,
        op2:       op2,
        dest_prn:  dest_prn
    };

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            free_vec[i] = !entries[i].valid;
            alu_req[i]  = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                          && fu_of(entries[i].op) == fu_alu && alu_enable;
            mult_req[i] = entries[i].valid && entries[i].op1_ready && entries[i].op2_ready
                          && fu_of(entries[i].op) == fu_mult && mult_enable;
        end
    end

    assign alloc     = dispatch_fire ? lowest(free_vec) : '0;
    assign alu_gnt   = lowest(alu_req);
    assign mult_gnt  = lowest(mult_req);
    assign alu_fire  = |alu_gnt;
    assign mult_fire = |mult_gnt;

    // one-hot mux of the granted entries
    always_comb begin
        alu_pick  = '0;
        mult_pick = '0;
        for (int i = 0; i < rs_size; i++) begin
            if (alu_gnt[i]) begin
                alu_pick = entries[i];
            end
            if (mult_gnt[i]) begin
                mult_pick = entries[i];
            end
        end
    end

    assign alu_issue.valid     = alu_fire;
    assign alu_issue.op        = alu_pick.op;
    assign alu_issue.op1       = alu_pick.op1;
    assign alu_issue.op2       = alu_pick.op2;
    assign alu_issue.dest_prn  = alu_pick.dest_prn;

    assign mult_issue.valid    = mult_fire;
    assign mult_issue.op       = mult_pick.op;
    assign mult_issue.op1      = mult_pick.op1;
    assign mult_issue.op2      = mult_pick.op2;
    assign mult_issue.dest_prn = mult_pick.dest_prn;

    always_comb begin
        for (int i = 0; i < rs_size; i++) begin
            next_entries[i] = wake(entries[i]);
            if (alu_gnt[i] || mult_gnt[i]) begin
                next_entries[i].valid = 1'b0;   // leaves at the issue edge
            end
            if (alloc[i]) begin
                next_entries[i] = wake(incoming);   // snoop on the way in
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            occupancy <= '0;
            for (int i = 0; i < rs_size; i++) begin
                entries[i].valid <= 1'b0;
            end
        end else begin
            occupancy <= occupancy + cnt_w'(dispatch_fire)
                         - cnt_w'(alu_fire) - cnt_w'(mult_fire);
            entries   <= next_entries;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rs_regs.sv ====
`timescale 1ns/1ns
`default_nettype none

module rs_regs import issue_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              psel,
    input  logic              penable,
    input  logic              pwrite,
    input  logic [addr_w-1:0] paddr,
    input  logic [data_w-1:0] pwdata,
    output logic [data_w-1:0] prdata,
    output logic              pready,
    output logic              pslverr,
    input  logic [cnt_w-1:0]  occupancy,
    input  logic              alu_issued,
    input  logic              mult_issued,
    output logic              alu_enable,
    output logic              mult_enable,
    output logic [cnt_w-1:0]  alert_depth
);

    logic [data_w-1:0] alu_cnt;
    logic [data_w-1:0] mult_cnt;
    logic              access;
    logic              write_ok;
    logic              bad_access;
    logic              alert_bad;

    assign access    = psel && penable;
    assign alert_bad = pwdata == '0 || pwdata > data_w'(rs_size);

    // read mux and error decode
    always_comb begin
        prdata     = '0;
        bad_access = 1'b0;
        case (paddr)
            addr_ctrl:     prdata = data_w'({mult_enable, alu_enable});
            addr_alert: begin
                prdata     = data_w'(alert_depth);
                bad_access = pwrite && alert_bad;
            end
            addr_status: begin
                prdata     = data_w'(occupancy);
                bad_access = pwrite;   // read only
            end
            addr_alu_cnt: begin
                prdata     = alu_cnt;
                bad_access = pwrite;
            end
            addr_mult_cnt: begin
                prdata     = mult_cnt;
                bad_access = pwrite;
            end
            default:       bad_access = 1'b1;
        endcase
    end

    assign pready   = access;   // zero wait states
    assign pslverr  = access && bad_access;
    assign write_ok = access && pwrite && !bad_access;

    always_ff @(posedge clock) begin
        if (reset) begin
            alu_enable  <= 1'b1;
            mult_enable <= 1'b1;
            alert_depth <= cnt_w'(1);
            alu_cnt     <= '0;
            mult_cnt    <= '0;
        end else begin
            if (write_ok && paddr == addr_ctrl) begin
                alu_enable  <= pwdata[0];
                mult_enable <= pwdata[1];
            end
            if (write_ok && paddr == addr_alert) begin
                alert_depth <= pwdata[cnt_w-1:0];
            end
            alu_cnt  <= alu_cnt + data_w'(alu_issued);    // wraps
            mult_cnt <= mult_cnt + data_w'(mult_issued);
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the issue stage testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f flist.f --top-module tb_issue_top \
    -Mdir obj_dir -o sim_issue > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/sim_issue > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTBENCH FAILED" sim.log; then
    exit 1
fi
exit 0

// ==== tb/issue_model.svh ====
`ifndef ISSUE_MODEL_SVH
`define ISSUE_MODEL_SVH

// model state per dispatched op in dispatch order
logic [31:0] exp_val [256];
int          prod1 [256];     // -1 when the operand came in ready
int          prod2 [256];
int          tag_of [256];
bit          seen [256];
bit          is_mult [256];
int          owner [64];      // op id that currently holds each tag
bit          busy [64];
int          n_ops, outstanding, alu_ops, mult_ops;
int          errors, timeouts;
int          seed = 90;

function automatic logic [31:0] model_result(input op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
    case (op)
        op_add:  return a + b;
        op_sub:  return a - b;
        op_and:  return a & b;
        op_xor:  return a ^ b;
        op_mul:  return a * b;   // low 32 bits
        default: return '0;
    endcase
endfunction

// one zero-wait apb transfer that hands back read data and error flag
task automatic apb_access(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic err);
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    assert (pready) else begin
        $display("[ERROR] %0t pready got 0 expected 1", $time);
        errors++;
    end
    rdata = prdata;
    err   = pslverr;
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
endtask

task automatic apb_check(input bit wr, input logic [7:0] addr, input logic [31:0] wdata,
                         input bit exp_err, input logic [31:0] exp_rd);
    logic [31:0] rd;
    logic        err;
    apb_access(wr, addr, wdata, rd, err);
    assert (err == exp_err) else begin
        $display("[ERROR] %0t pslverr at addr %h got %0b expected %0b",
                 $time, addr, err, exp_err);
        errors++;
    end
    if (!wr) begin
        assert (rd == exp_rd) else begin
            $display("[ERROR] %0t prdata at addr %h got %h expected %h",
                     $time, addr, rd, exp_rd);
            errors++;
        end
    end
endtask

`endif

// ==== tb/tb_issue_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_issue_top import issue_pkg::*; ();

    logic clock, reset, dispatch_valid, op1_ready, op2_ready, dispatch_ready;
    logic psel, penable, pwrite, pready, pslverr;
    op_e  dispatch_op;
    logic [31:0] op1, op2, pwdata, prdata;
    logic [5:0]  dest_prn;
    logic [7:0]  paddr;
    logic [1:0]  cdb_valid;
    logic [1:0][5:0]  cdb_prn;
    logic [1:0][31:0] cdb_value;
    bit   quiet [2];   // lane must stay silent while set
    int   k, alert_v;

    `include "issue_model.svh"

    issue_top dut0 (.*);

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    task automatic finish_run();
        $display("errors %0d, timeouts %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) $display("TESTBENCH PASSED");
        else $display("TESTBENCH FAILED");
        $finish;
    endtask

    task automatic timed_out(input string what);
        $display("timeout while waiting for %s", what);
        timeouts++;
        finish_run();
    endtask

    // kind 0 any op, 1 alu only, 2 mul only
    task automatic dispatch_one(input int kind, input bit force_ready);
        int tag, t, id, p;
        op_e op;
        logic [31:0] v [2];
        int pr [2];
        t   = 0;
        id  = n_ops;
        tag = $unsigned($random(seed)) % 64;
        while (busy[tag]) tag = (tag + 1) % 64;
        if (kind == 2) op = op_mul;
        else if (kind == 1) op = op_e'(3'($unsigned($random(seed)) % 4));
        else op = op_e'(3'($unsigned($random(seed)) % 5));
        forever begin
            @(posedge clock);
            for (int j = 0; j < 2; j++) begin
                pr[j] = -1;
                v[j]  = $random(seed);
                if (!force_ready && outstanding > 0 && v[j][0]) begin
                    p = $unsigned($random(seed)) % n_ops;
                    while (seen[p]) p = (p + 1) % n_ops;   // some op still in flight
                    pr[j] = p;
                end
            end
            dispatch_valid <= 1'b1;
            dispatch_op    <= op;
            dest_prn       <= 6'(tag);
            op1_ready      <= pr[0] < 0;
            op2_ready      <= pr[1] < 0;
            op1            <= (pr[0] < 0) ? v[0] : 32'(tag_of[pr[0] < 0 ? 0 : pr[0]]);
            op2            <= (pr[1] < 0) ? v[1] : 32'(tag_of[pr[1] < 0 ? 0 : pr[1]]);
            @(negedge clock);
            if (dispatch_ready) break;
            t++;
            if (t > 200) timed_out("dispatch_ready");
        end
        for (int j = 0; j < 2; j++) if (pr[j] >= 0) v[j] = exp_val[pr[j]];
        exp_val[id] = model_result(op, v[0], v[1]);
        prod1[id]   = pr[0];
        prod2[id]   = pr[1];
        tag_of[id]  = tag;
        is_mult[id] = op == op_mul;
        owner[tag]  = id;
        busy[tag]   = 1'b1;
        if (op == op_mul) mult_ops++;
        else alu_ops++;
        n_ops++;
        outstanding++;
        @(posedge clock);
        dispatch_valid <= 1'b0;
    endtask

    task automatic drain();
        int t;
        t = 0;
        while (outstanding > 0 && t < 2000) begin
            @(negedge clock);
            t++;
        end
        if (outstanding > 0) timed_out("all results to drain");
    endtask

    // cdb monitor samples mid-cycle
    always @(negedge clock) begin : monitor
        int id;
        bit fin [2];
        if (!reset) begin
            for (int l = 0; l < 2; l++) begin
                fin[l] = 1'b0;
                if (cdb_valid[l]) begin
                    assert (!quiet[l]) else begin
                        $display("lane %0d broadcast while its unit was disabled", l);
                        errors++;
                    end
                    assert (busy[cdb_prn[l]]) else begin
                        $display("tag %0d on lane %0d is not in flight", cdb_prn[l], l);
                        errors++;
                    end
                    if (busy[cdb_prn[l]]) begin
                        id     = owner[cdb_prn[l]];
                        fin[l] = 1'b1;
                        assert (cdb_value[l] == exp_val[id]) else begin
                            $display("[ERROR] %0t cdb_value[%0d] got %h expected %h",
                                     $time, l, cdb_value[l], exp_val[id]);
                            errors++;
                        end
                        assert (l == int'(is_mult[id])) else begin
                            $display("[ERROR] %0t cdb lane got %0d expected %0d",
                                     $time, l, is_mult[id]);
                            errors++;
                        end
                        assert ((prod1[id] < 0 || seen[prod1[id] < 0 ? 0 : prod1[id]]) &&
                                (prod2[id] < 0 || seen[prod2[id] < 0 ? 0 : prod2[id]]))
                        else begin
                            $display("tag %0d finished before its producers", cdb_prn[l]);
                            errors++;
                        end
                    end
                end
            end
            for (int l = 0; l < 2; l++) begin
                if (fin[l]) begin
                    seen[owner[cdb_prn[l]]] = 1'b1;
                    busy[cdb_prn[l]]        = 1'b0;
                    outstanding--;
                end
            end
        end
    end

    initial begin
        reset = 1'b1;
        {dispatch_valid, op1_ready, op2_ready, psel, penable, pwrite} = '0;
        dispatch_op = op_add;
        {op1, op2, pwdata, paddr, dest_prn} = '0;
        repeat (3) @(posedge clock);
        reset <= 1'b0;
        @(negedge clock);
        assert (dispatch_ready && cdb_valid == 2'b00 && !pslverr) else begin
            $display("outputs not idle after reset");
            errors++;
        end
        apb_check(0, addr_ctrl, 0, 0, 3);
        apb_check(0, addr_alert, 0, 0, 1);
        apb_check(0, addr_status, 0, 0, 0);
        apb_check(0, 8'h14, 0, 1, 0);          // unmapped
        apb_check(1, 8'h20, 5, 1, 0);
        apb_check(1, addr_status, 5, 1, 0);    // read only
        apb_check(1, addr_alu_cnt, 5, 1, 0);
        apb_check(1, addr_mult_cnt, 5, 1, 0);
        apb_check(1, addr_alert, 0, 1, 0);     // out of range
        apb_check(1, addr_alert, 9, 1, 0);
        apb_check(0, addr_ctrl, 0, 0, 3);
        apb_check(0, addr_alert, 0, 0, 1);
        apb_check(0, addr_status, 0, 0, 0);
        apb_check(0, addr_alu_cnt, 0, 0, 0);
        apb_check(0, addr_mult_cnt, 0, 0, 0);
        repeat (60) dispatch_one(0, 0);
        drain();
        // lane 0 via ctrl=2, lane 1 via ctrl=1
        for (int u = 0; u < 2; u++) begin
            apb_check(1, addr_ctrl, (u == 0) ? 2 : 1, 0, 0);
            repeat (4) @(posedge clock);
            quiet[u] = 1'b1;
            repeat (6) dispatch_one(u + 1, 0);
            repeat (10) @(posedge clock);
            quiet[u] = 1'b0;
            apb_check(1, addr_ctrl, 3, 0, 0);
            drain();
        end
        for (int s = 0; s < 3; s++) begin
            alert_v = 1 + 2 * s;
            apb_check(1, addr_ctrl, 0, 0, 0);
            apb_check(1, addr_alert, alert_v, 0, 0);
            k = 0;
            while (k < 10) begin
                @(negedge clock);
                // ready drops once the count exceeds the size less the alert value
                assert (dispatch_ready == !(k > rs_size - alert_v)) else begin
                    $display("[ERROR] %0t dispatch_ready got %0b expected %0b", $time,
                             dispatch_ready, !(k > rs_size - alert_v));
                    errors++;
                end
                if (!dispatch_ready) break;
                dispatch_one(0, 1);
                k++;
            end
            apb_check(0, addr_status, 0, 0, k);
            apb_check(1, addr_ctrl, 3, 0, 0);
            drain();
        end
        apb_check(0, addr_alu_cnt, 0, 0, alu_ops);
        apb_check(0, addr_mult_cnt, 0, 0, mult_ops);
        finish_run();
    end

endmodule

`default_nettype wire
